//--- source/uart_dbg_consts.svh
// Debug protocol byte codes, memory size, argument lengths and counter widths

`ifndef UART_DBG_CONSTS_SVH
`define UART_DBG_CONSTS_SVH

//////////////////////////////
// Protocol byte codes
//////////////////////////////

`define DBG_CMD_READ   8'h11
`define DBG_CMD_WRITE  8'h12
`define DBG_CMD_EXEC   8'h13
`define DBG_ACK        8'h06
`define DBG_EOT        8'h04
`define DBG_EOC        8'h14

//////////////////////////////
// Lengths and widths
//////////////////////////////

// Bytes per address or length argument
`define DBG_ARG_BYTES  8
// Exit code bytes after EOC
`define DBG_EXIT_BYTES 4

// Scratch memory is 2**DBG_MEM_AW bytes
`define DBG_MEM_AW     8
`define DBG_LEN_W      16
// Counts both argument bytes and exit code bytes
`define DBG_ARG_CNT_W  4

`endif

//--- source/uart_dbg_pkg.sv
// Packed struct types for bytes, exec reports and EOC requests

package uart_dbg_pkg;

  //////////////////////////////
  // Byte transfer
  //////////////////////////////

  // One byte with a single-cycle strobe
  typedef struct packed {
    logic       strb;
    logic [7:0] data;
  } byte_strobe_t;

  //////////////////////////////
  // System side
  //////////////////////////////

  // Entry address reported by the exec command
  typedef struct packed {
    logic        valid;
    logic [63:0] entry;
  } exec_t;

  // End of computation with its exit code
  // Request is held until the engine starts replying
  typedef struct packed {
    logic        req;
    logic [31:0] code;
  } eoc_t;

endpackage

//--- source/uart_rx.sv
// Oversampling UART receiver with optional even parity check

`timescale 1ns/1ps

module uart_rx #(
  parameter int clks_per_bit = 16,
  parameter bit parity_ena   = 0
) (
  input  logic                      clk,
  input  logic                      arst_n_i,
  input  logic                      uart_rx_i,
  output uart_dbg_pkg::byte_strobe_t rx_byte_o
);

  localparam int cnt_w = $clog2(clks_per_bit + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_PARITY,
    ST_STOP
  } rx_state_e;

  rx_state_e        state_q;
  logic [1:0]       sync_q;
  logic [cnt_w-1:0] cnt_q;
  logic [2:0]       bit_idx_q;
  logic             par_ok_q;
  logic             strb_q;
  logic [7:0]       shreg_q;
  logic             rx_s;
  logic             half_hit;
  logic             full_hit;

  assign rx_s     = sync_q[1];
  assign half_hit = (cnt_q == cnt_w'(clks_per_bit / 2 - 1));
  assign full_hit = (cnt_q == cnt_w'(clks_per_bit - 1));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q    <= 2'b11;
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      bit_idx_q <= '0;
      par_ok_q  <= 1'b1;
      strb_q    <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], uart_rx_i};
      strb_q <= 1'b0;
      cnt_q  <= (state_q == ST_IDLE || full_hit) ? '0 : cnt_q + 1'b1;
      case (state_q)
        ST_IDLE: if (!rx_s) state_q <= ST_START;
        // Confirm the start bit at half a bit period
        ST_START: if (half_hit) begin
          cnt_q     <= '0;
          bit_idx_q <= '0;
          par_ok_q  <= 1'b1;
          state_q   <= rx_s ? ST_IDLE : ST_DATA;
        end
        ST_DATA: if (full_hit) begin
          bit_idx_q <= bit_idx_q + 1'b1;
          if (bit_idx_q == 3'd7) state_q <= parity_ena ? ST_PARITY : ST_STOP;
        end
        ST_PARITY: if (full_hit) begin
          par_ok_q <= (rx_s == ^shreg_q);
          state_q  <= ST_STOP;
        end
        ST_STOP: if (full_hit) begin
          strb_q  <= rx_s & par_ok_q;
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state_q == ST_DATA && full_hit) shreg_q <= {rx_s, shreg_q[7:1]};
  end

  assign rx_byte_o.strb = strb_q;
  assign rx_byte_o.data = shreg_q;

endmodule

//--- source/uart_tx.sv
// UART transmitter with optional even parity bit

`timescale 1ns/1ps

module uart_tx #(
  parameter int clks_per_bit = 16,
  parameter bit parity_ena   = 0
) (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  uart_dbg_pkg::byte_strobe_t tx_byte_i,
  output logic                       tx_ready_o,
  output logic                       uart_tx_o
);

  localparam int cnt_w      = $clog2(clks_per_bit + 1);
  localparam int frame_bits = parity_ena ? 11 : 10;

  logic [10:0]      frame_q;
  logic [cnt_w-1:0] baud_cnt_q;
  logic [3:0]       bit_cnt_q;
  logic             ready_q;
  logic [10:0]      frame_d;

  // Start bit, data, then parity or a second stop bit, then stop
  assign frame_d = parity_ena ? {1'b1, ^tx_byte_i.data, tx_byte_i.data, 1'b0}
                              : {2'b11, tx_byte_i.data, 1'b0};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      frame_q    <= '1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      ready_q    <= 1'b1;
    end else if (ready_q) begin
      if (tx_byte_i.strb) begin
        frame_q    <= frame_d;
        baud_cnt_q <= '0;
        bit_cnt_q  <= '0;
        ready_q    <= 1'b0;
      end
    end else if (baud_cnt_q == cnt_w'(clks_per_bit - 1)) begin
      baud_cnt_q <= '0;
      // Shift in idle level behind the frame
      frame_q    <= {1'b1, frame_q[10:1]};
      if (bit_cnt_q == 4'(frame_bits - 1)) begin
        bit_cnt_q <= '0;
        ready_q   <= 1'b1;
      end else begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  assign uart_tx_o  = frame_q[0];
  assign tx_ready_o = ready_q;

endmodule

//--- source/dbg_cmd_engine.sv
// Debug protocol FSM with scratch memory, exec report and EOC reply

`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module dbg_cmd_engine (
  input  logic                       clk,
  input  logic                       arst_n_i,
  input  uart_dbg_pkg::byte_strobe_t rx_byte_i,
  input  logic                       tx_ready_i,
  output uart_dbg_pkg::byte_strobe_t tx_byte_o,
  output uart_dbg_pkg::exec_t        exec_o,
  input  uart_dbg_pkg::eoc_t         eoc_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ARGS,
    ST_WDATA,
    ST_RDATA,
    ST_EOT,
    ST_EOC
  } eng_state_e;

  eng_state_e                state_q, state_d;
  logic [7:0]                cmd_q;
  logic [`DBG_ARG_CNT_W-1:0] arg_cnt_q;
  logic [`DBG_MEM_AW-1:0]    ptr_q;
  logic [`DBG_LEN_W-1:0]     data_cnt_q;
  logic                      pend_q;
  logic                      exec_valid_q;

  logic [63:0]               addr_q;
  logic [`DBG_LEN_W-1:0]     len_q;
  logic [31:0]               exit_q;
  logic [7:0]                pend_data_q;
  logic [7:0]                mem_q [2**`DBG_MEM_AW];

  logic       push;
  logic [7:0] push_data;
  logic       cmd_take;
  logic       arg_step;
  logic       xfer_start;
  logic       mem_we;
  logic       mem_rd;
  logic       exec_fire;
  logic       eoc_take;
  logic       exit_step;

  //////////////////////////////
  // Next state decode
  //////////////////////////////

  always_comb begin
    state_d    = state_q;
    push       = 1'b0;
    push_data  = `DBG_ACK;
    cmd_take   = 1'b0;
    arg_step   = 1'b0;
    xfer_start = 1'b0;
    mem_we     = 1'b0;
    mem_rd     = 1'b0;
    exec_fire  = 1'b0;
    eoc_take   = 1'b0;
    exit_step  = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (rx_byte_i.strb) begin
          case (rx_byte_i.data)
            `DBG_ACK: push = 1'b1;
            `DBG_CMD_READ, `DBG_CMD_WRITE, `DBG_CMD_EXEC: begin
              cmd_take = 1'b1;
              state_d  = ST_ARGS;
            end
            default: ;
          endcase
        end else if (eoc_i.req && !pend_q) begin
          push      = 1'b1;
          push_data = `DBG_EOC;
          eoc_take  = 1'b1;
          state_d   = ST_EOC;
        end
      end
      // Address first, then length, both little endian
      ST_ARGS: if (rx_byte_i.strb) begin
        arg_step = 1'b1;
        if (cmd_q == `DBG_CMD_EXEC && arg_cnt_q == `DBG_ARG_BYTES - 1) begin
          push      = 1'b1;
          exec_fire = 1'b1;
          state_d   = ST_IDLE;
        end else if (arg_cnt_q == 2 * `DBG_ARG_BYTES - 1) begin
          push       = 1'b1;
          xfer_start = 1'b1;
          if (cmd_q == `DBG_CMD_READ) state_d = ST_RDATA;
          else state_d = (len_q == '0) ? ST_EOT : ST_WDATA;
        end
      end
      ST_WDATA: if (rx_byte_i.strb) begin
        mem_we = 1'b1;
        if (data_cnt_q == `DBG_LEN_W'(1)) state_d = ST_EOT;
      end
      // Refill the reply slot as soon as it empties
      ST_RDATA: if (!pend_q) begin
        push = 1'b1;
        if (data_cnt_q != '0) begin
          push_data = mem_q[ptr_q];
          mem_rd    = 1'b1;
        end else begin
          push_data = `DBG_EOT;
          state_d   = ST_IDLE;
        end
      end
      ST_EOT: if (!pend_q) begin
        push      = 1'b1;
        push_data = `DBG_EOT;
        state_d   = ST_IDLE;
      end
      ST_EOC: if (!pend_q) begin
        push      = 1'b1;
        push_data = exit_q[7:0];
        exit_step = 1'b1;
        if (arg_cnt_q == `DBG_EXIT_BYTES - 1) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  //////////////////////////////
  // Control registers
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= ST_IDLE;
      cmd_q        <= '0;
      arg_cnt_q    <= '0;
      ptr_q        <= '0;
      data_cnt_q   <= '0;
      pend_q       <= 1'b0;
      exec_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      exec_valid_q <= exec_fire;
      if (push) pend_q <= 1'b1;
      else if (tx_byte_o.strb) pend_q <= 1'b0;
      if (cmd_take) cmd_q <= rx_byte_i.data;
      // Argument index doubles as exit code byte index
      if (cmd_take || eoc_take) arg_cnt_q <= '0;
      else if (arg_step || exit_step) arg_cnt_q <= arg_cnt_q + 1'b1;
      if (xfer_start) begin
        ptr_q      <= addr_q[`DBG_MEM_AW-1:0];
        data_cnt_q <= len_q;
      end else if (mem_we || mem_rd) begin
        ptr_q      <= ptr_q + 1'b1;
        data_cnt_q <= data_cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////
  // Payload and memory
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (push) pend_data_q <= push_data;
    if (arg_step) begin
      if (arg_cnt_q < `DBG_ARG_BYTES) addr_q <= {rx_byte_i.data, addr_q[63:8]};
      // Only the two low length bytes are kept
      else if (arg_cnt_q < `DBG_ARG_BYTES + 2) len_q <= {rx_byte_i.data, len_q[15:8]};
    end
    if (eoc_take) exit_q <= eoc_i.code;
    else if (exit_step) exit_q <= {8'h00, exit_q[31:8]};
    if (mem_we) mem_q[ptr_q] <= rx_byte_i.data;
  end

  assign tx_byte_o.strb = pend_q & tx_ready_i;
  assign tx_byte_o.data = pend_data_q;

  assign exec_o.valid = exec_valid_q;
  assign exec_o.entry = addr_q;

endmodule

//--- source/uart_dbg_top.sv
// UART debug server top with receiver, command engine and transmitter

`timescale 1ns/1ps

module uart_dbg_top #(
  parameter int clks_per_bit = 16,
  parameter bit parity_ena   = 0
) (
  input  logic                clk,
  input  logic                arst_n_i,
  input  logic                uart_rx_i,
  output logic                uart_tx_o,
  input  uart_dbg_pkg::eoc_t  eoc_i,
  output uart_dbg_pkg::exec_t exec_o
);

  uart_dbg_pkg::byte_strobe_t rx_byte;
  uart_dbg_pkg::byte_strobe_t tx_byte;
  logic                       tx_ready;

  uart_rx #(
    .clks_per_bit ( clks_per_bit ),
    .parity_ena   ( parity_ena   )
  ) u_rx (
    .clk       ( clk       ),
    .arst_n_i  ( arst_n_i  ),
    .uart_rx_i ( uart_rx_i ),
    .rx_byte_o ( rx_byte   )
  );

  dbg_cmd_engine u_engine (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n_i ),
    .rx_byte_i  ( rx_byte  ),
    .tx_ready_i ( tx_ready ),
    .tx_byte_o  ( tx_byte  ),
    .exec_o     ( exec_o   ),
    .eoc_i      ( eoc_i    )
  );

  uart_tx #(
    .clks_per_bit ( clks_per_bit ),
    .parity_ena   ( parity_ena   )
  ) u_tx (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .tx_byte_i  ( tx_byte   ),
    .tx_ready_o ( tx_ready  ),
    .uart_tx_o  ( uart_tx_o )
  );

endmodule

//--- testbench/uart_dbg_checker.sv
// Serial output decoder and comparator for reply bytes and exec reports

`timescale 1ns/1ps

module uart_dbg_checker #(
  parameter int clks_per_bit = 16
) (
  input logic                clk,
  input logic                arst_n_i,
  input logic                tx_line_i,
  input uart_dbg_pkg::exec_t exec_i
);

  // Filled by the reference model, drained here
  logic [7:0]  exp_bytes [$];
  logic [63:0] exp_exec [$];
  logic        busy = 1'b0;
  int          mismatch_cnt = 0;
  int          fault_cnt = 0;
  logic [7:0]  rx_data;
  logic        rx_par;
  logic        rx_stop;
  logic [7:0]  exp_byte;
  logic [63:0] exp_entry;

  task automatic check_byte();
    if (rx_par !== ^rx_data || rx_stop !== 1'b1) begin
      fault_cnt++;
      $display("Bad parity or stop bit on uart_tx_o byte 0x%02h at %0t", rx_data, $time);
    end
    if (exp_bytes.size() == 0) begin
      fault_cnt++;
      $display("Unexpected byte 0x%02h on uart_tx_o at %0t", rx_data, $time);
    end else begin
      exp_byte = exp_bytes.pop_front();
      if (rx_data !== exp_byte) begin
        mismatch_cnt++;
        $display("MISMATCH uart_tx_o byte: got 0x%02h expected 0x%02h at %0t",
                 rx_data, exp_byte, $time);
      end
    end
  endtask

  //////////////////////////////
  // Serial byte decoder
  //////////////////////////////

  always begin
    @(negedge clk);
    if (arst_n_i && tx_line_i === 1'b0) begin
      busy = 1'b1;
      // Middle of the start bit
      repeat (clks_per_bit / 2) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (clks_per_bit) @(negedge clk);
        rx_data[i] = tx_line_i;
      end
      repeat (clks_per_bit) @(negedge clk);
      rx_par = tx_line_i;
      repeat (clks_per_bit) @(negedge clk);
      rx_stop = tx_line_i;
      check_byte();
      busy = 1'b0;
    end
  end

  // Valid is a single-cycle pulse
  always @(negedge clk) begin
    if (arst_n_i && exec_i.valid === 1'b1) begin
      if (exp_exec.size() == 0) begin
        fault_cnt++;
        $display("exec_o.valid pulsed with no exec command outstanding at %0t", $time);
      end else begin
        exp_entry = exp_exec.pop_front();
        if (exec_i.entry !== exp_entry) begin
          mismatch_cnt++;
          $display("MISMATCH exec_o.entry: got 0x%016h expected 0x%016h",
                   exec_i.entry, exp_entry);
        end
      end
    end
  end

endmodule

//--- testbench/tb_uart_dbg.sv
// Testbench top with clock, reset, xorshift stimulus, serial driver and reference model

`timescale 1ns/1ps

`include "uart_dbg_consts.svh"

module tb_uart_dbg;

  localparam int clks_per_bit = 8;

  logic                clk = 1'b0;
  logic                arst_n;
  logic                uart_rx;
  logic                uart_tx;
  uart_dbg_pkg::eoc_t  eoc;
  uart_dbg_pkg::exec_t exec;
  logic [31:0]         rng_state;
  logic [7:0]          mem_model [256];
  int                  timeout_cnt;
  int                  leftover_cnt;

  always #4 clk = ~clk;

  uart_dbg_top #(.clks_per_bit(clks_per_bit), .parity_ena(1'b1)) dut_i (
    .clk       ( clk     ),
    .arst_n_i  ( arst_n  ),
    .uart_rx_i ( uart_rx ),
    .uart_tx_o ( uart_tx ),
    .eoc_i     ( eoc     ),
    .exec_o    ( exec    )
  );

  uart_dbg_checker #(.clks_per_bit(clks_per_bit)) chk_i (
    .clk       ( clk     ),
    .arst_n_i  ( arst_n  ),
    .tx_line_i ( uart_tx ),
    .exec_i    ( exec    )
  );

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] lo;
    lo = xorshift32();
    return {xorshift32(), lo};
  endfunction

  function automatic bit replies_pending();
    return chk_i.exp_bytes.size() != 0 || chk_i.exp_exec.size() != 0 || chk_i.busy;
  endfunction

  //////////////////////////////
  // Serial driver
  //////////////////////////////

  // Start, 8 data bits LSB first, even parity, stop
  task automatic send_byte(input logic [7:0] data, input bit good_par);
    logic [10:0] frame;
    frame = {1'b1, (^data) ^ ~good_par, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      uart_rx = frame[i];
      repeat (clks_per_bit) @(negedge clk);
    end
  endtask

  task automatic send_arg(input logic [63:0] value);
    for (int i = 0; i < `DBG_ARG_BYTES; i++) send_byte(value[8*i +: 8], 1'b1);
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (replies_pending() && n < 5000) begin
      @(posedge clk);
      n++;
    end
    if (replies_pending()) begin
      timeout_cnt++;
      $display("Timed out waiting for the DUT to finish its reply at %0t", $time);
    end
    @(negedge clk);
  endtask

  //////////////////////////////
  // Commands and model
  //////////////////////////////

  task automatic write_block(input logic [63:0] addr, input logic [15:0] len);
    logic [7:0] p;
    logic [7:0] d;
    chk_i.exp_bytes.push_back(`DBG_ACK);
    chk_i.exp_bytes.push_back(`DBG_EOT);
    send_byte(`DBG_CMD_WRITE, 1'b1);
    send_arg(addr);
    // Upper length bytes are ignored by the DUT
    send_arg({rand64() & 64'hffff_ffff_ffff_0000} | 64'(len));
    p = addr[7:0];
    for (int i = 0; i < int'(len); i++) begin
      d = 8'(xorshift32());
      mem_model[p] = d;
      p++;
      send_byte(d, 1'b1);
    end
    wait_drained();
  endtask

  task automatic read_block(input logic [63:0] addr, input logic [15:0] len);
    logic [7:0] p;
    p = addr[7:0];
    chk_i.exp_bytes.push_back(`DBG_ACK);
    for (int i = 0; i < int'(len); i++) begin
      chk_i.exp_bytes.push_back(mem_model[p]);
      p++;
    end
    chk_i.exp_bytes.push_back(`DBG_EOT);
    send_byte(`DBG_CMD_READ, 1'b1);
    send_arg(addr);
    send_arg(64'(len));
    wait_drained();
  endtask

  task automatic ack_challenge(input bit good_par);
    if (good_par) chk_i.exp_bytes.push_back(`DBG_ACK);
    send_byte(`DBG_ACK, good_par);
    if (good_par) wait_drained();
    // Silence window for a dropped byte
    else repeat (30 * clks_per_bit) @(negedge clk);
  endtask

  task automatic exec_entry();
    logic [63:0] entry;
    entry = rand64();
    chk_i.exp_exec.push_back(entry);
    chk_i.exp_bytes.push_back(`DBG_ACK);
    send_byte(`DBG_CMD_EXEC, 1'b1);
    send_arg(entry);
    wait_drained();
  endtask

  task automatic raise_eoc();
    logic [31:0] code;
    int          n;
    code = xorshift32();
    chk_i.exp_bytes.push_back(`DBG_EOC);
    for (int i = 0; i < `DBG_EXIT_BYTES; i++) chk_i.exp_bytes.push_back(code[8*i +: 8]);
    eoc.code = code;
    eoc.req  = 1'b1;
    // Hold the request until the EOC start bit appears
    n = 0;
    while (uart_tx !== 1'b0 && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (uart_tx !== 1'b0) begin
      timeout_cnt++;
      $display("Timed out waiting for the EOC reply to start at %0t", $time);
    end
    eoc.req = 1'b0;
    wait_drained();
  endtask

  initial begin
    logic [31:0] op;
    logic [63:0] blk_addr;
    logic [15:0] blk_len;
    arst_n       = 1'b0;
    uart_rx      = 1'b1;
    eoc          = '0;
    rng_state    = 32'd77092;
    timeout_cnt  = 0;
    leftover_cnt = 0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    repeat (clks_per_bit) @(negedge clk);

    ack_challenge(1'b1);
    blk_addr = rand64();
    blk_len  = 16'(1 + xorshift32() % 16);
    write_block(blk_addr, blk_len);
    read_block(blk_addr, blk_len);
    // Range that wraps past the top of memory
    write_block(64'h0000_0000_0000_00f8, 16'd16);
    read_block(64'h0000_0000_0000_00f8, 16'd16);
    exec_entry();
    raise_eoc();
    ack_challenge(1'b0);
    ack_challenge(1'b1);

    // Fill the whole memory so any range can be read back
    write_block(rand64(), 16'd256);
    for (int i = 0; i < 20; i++) begin
      op = xorshift32() % 3;
      if (op == 0) write_block(rand64(), 16'(1 + xorshift32() % 16));
      else if (op == 1) read_block(rand64(), 16'(1 + xorshift32() % 16));
      else ack_challenge(1'b1);
    end

    leftover_cnt = chk_i.exp_bytes.size() + chk_i.exp_exec.size();
    if (leftover_cnt != 0) $display("%0d expected replies never arrived", leftover_cnt);
    $display("Errors: %0d mismatch, %0d protocol, %0d timeout, %0d leftover",
             chk_i.mismatch_cnt, chk_i.fault_cnt, timeout_cnt, leftover_cnt);
    if (chk_i.mismatch_cnt + chk_i.fault_cnt + timeout_cnt + leftover_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/uart_dbg_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/dbg_cmd_engine.sv
source/uart_dbg_top.sv
testbench/uart_dbg_checker.sv
testbench/tb_uart_dbg.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_uart_dbg -o sim_uart_dbg
./obj_dir/sim_uart_dbg | tee sim.log
if grep -q "^=== PASS ===$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
